// ==== src.f ====
+incdir+tests
verilog/numFormatPkg.sv
verilog/arithStreamPkg.sv
verilog/carryLookaheadAdder.sv
verilog/formatConverters.sv
verilog/trueFormArithStage.sv
verilog/resultChannel.sv
verilog/arithUnitTop.sv
tests/arithUnitTb.sv

// ==== Makefile ====
TOP = arithUnitTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/arithModel.svh ====
// Included inside arithUnitTb after its package imports; it owns the LFSR state and error counters.
`ifndef ARITH_MODEL_SVH
`define ARITH_MODEL_SVH

logic [15:0] lfsrState = 16'd7549;
int          checkCount;
int          errorCount;
int          testChecks;
int          testErrors;

// Taps 16, 14, 13 and 11. One step yields one bit.
function automatic logic lfsrBit();
    logic feedback;
    feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], feedback};
    return feedback;
endfunction

function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
        value = {value[30:0], lfsrBit()};
    end
    return value;
endfunction

// Exact integer arithmetic on sign and magnitude. Outside +-(2^31 - 1) only the flag is defined.
function automatic arithRsp_t modelResult(input arithReq_t req);
    longint    valueA;
    longint    valueB;
    longint    carry;
    longint    exact;
    longint    absValue;
    longint    limit;
    arithRsp_t rsp;
    limit = 64'sh7FFF_FFFF;
    valueA = longint'({33'd0, req.operandA.fields.magnitude});
    valueB = longint'({33'd0, req.operandB.fields.magnitude});
    carry = longint'({63'd0, req.carryIn});
    if (req.operandA.fields.sign) begin
        valueA = -valueA;
    end
    if (req.operandB.fields.sign) begin
        valueB = -valueB;
    end
    exact = (req.op == opAdd) ? valueA + valueB + carry : valueA - valueB - carry;
    absValue = (exact < 0) ? -exact : exact;
    rsp = '0;
    rsp.overflow = (exact > limit) || (exact < -limit);
    if (!rsp.overflow) begin
        rsp.result.fields.sign = (exact < 0);
        rsp.result.fields.magnitude = absValue[30:0];
        rsp.negative = (exact < 0);
    end
    return rsp;
endfunction

task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] expected);
    checkCount++;
    testChecks++;
    assert (got === expected) else begin
        $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected);
        errorCount++;
        testErrors++;
    end
endtask

task automatic checkTrue(input logic condition, input string message);
    checkCount++;
    testChecks++;
    assert (condition) else begin
        $display("Error: %s", message);
        errorCount++;
        testErrors++;
    end
endtask

`endif

// ==== tests/arithUnitTb.sv ====
// Needs a simulator with timing support; results are compared at the falling clock edge.
`timescale 1ns/1ps

module arithUnitTb;
    import numFormatPkg::*;
    import arithStreamPkg::*;

    localparam int waitLimit = 1000;

    logic      clk;
    logic      arstN;
    logic      reqValid;
    arithReq_t reqData;
    logic      reqCredit;
    logic      rspCredit;
    logic      rspValid;
    arithRsp_t rspData;

    `include "arithModel.svh"

    arithRsp_t expectedQ[$];
    int        upCredits;
    int        downOutstanding;
    int        pendingGrants;
    logic      grantAlways;
    logic      grantNext;
    int        resultCount;
    int        reqCreditCount;
    int        testIndex;

    arithUnitTop uut (
        .clk       (clk),
        .arstN     (arstN),
        .reqValid  (reqValid),
        .reqData   (reqData),
        .reqCredit (reqCredit),
        .rspCredit (rspCredit),
        .rspValid  (rspValid),
        .rspData   (rspData)
    );

    always #50 clk = ~clk;

    // Scoreboard, upstream credit return and the downstream credit decision for the next cycle.
    always @(negedge clk) begin
        arithRsp_t expected;
        if (arstN && rspValid) begin
            resultCount++;
            downOutstanding--;
            if (expectedQ.size() == 0) begin
                checkTrue(1'b0, "a result arrived while none was expected");
            end else begin
                expected = expectedQ.pop_front();
                checkField("rspData.overflow", 32'(rspData.overflow), 32'(expected.overflow));
                if (!expected.overflow) begin
                    checkField("rspData.result", rspData.result.raw, expected.result.raw);
                    checkField("rspData.negative", 32'(rspData.negative),
                               32'(expected.negative));
                end
            end
        end
        if (arstN && reqCredit) begin
            reqCreditCount++;
            upCredits++;
        end
        grantNext = 1'b0;
        if (arstN && grantAlways && downOutstanding < queueDepth) begin
            grantNext = 1'b1;
        end else if (arstN && pendingGrants > 0) begin
            grantNext = 1'b1;
            pendingGrants--;
        end
        if (grantNext) begin
            downOutstanding++;
        end
    end

    always @(posedge clk) begin
        #1;
        rspCredit = grantNext;
    end

    task automatic reportTimeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    task automatic applyReset();
        arstN = 1'b0;
        reqValid = 1'b0;
        grantAlways = 1'b0;
        pendingGrants = 0;
        repeat (5) @(posedge clk);
        #1;
        arstN = 1'b1;
        upCredits = queueDepth;
        downOutstanding = 0;
        expectedQ.delete();
    endtask

    task automatic sendRequest(input arithReq_t req);
        int waited;
        waited = 0;
        while (upCredits == 0) begin
            if (waited == waitLimit) reportTimeout("an upstream credit");
            @(posedge clk);
            #1;
            waited++;
        end
        reqValid = 1'b1;
        reqData = req;
        upCredits--;
        expectedQ.push_back(modelResult(req));
        @(posedge clk);
        #1;
        reqValid = 1'b0;
    endtask

    task automatic waitForDrain();
        int waited;
        waited = 0;
        while (expectedQ.size() != 0) begin
            if (waited == waitLimit) reportTimeout("all outstanding results");
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    task automatic waitForResults(input int target);
        int waited;
        waited = 0;
        while (resultCount < target) begin
            if (waited == waitLimit) reportTimeout("a granted result");
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    task automatic finishTest(input string name);
        testIndex++;
        $display("[%0d] %s: %0d checks, %0d errors", testIndex, name, testChecks, testErrors);
        testChecks = 0;
        testErrors = 0;
    endtask

    function automatic arithReq_t makeRequest(input logic signA, input logic [30:0] magA,
                                              input arithOp_t op, input logic signB,
                                              input logic [30:0] magB, input logic carry);
        arithReq_t req;
        req.operandA.fields.sign = signA;
        req.operandA.fields.magnitude = magA;
        req.operandB.fields.sign = signB;
        req.operandB.fields.magnitude = magB;
        req.op = op;
        req.carryIn = carry;
        return req;
    endfunction

    function automatic arithReq_t randomRequest(input int magBits);
        arithReq_t req;
        req.operandA.fields.sign = lfsrBit();
        req.operandA.fields.magnitude = magWidth'(randomBits(magBits));
        req.operandB.fields.sign = lfsrBit();
        req.operandB.fields.magnitude = magWidth'(randomBits(magBits));
        req.op = arithOp_t'(lfsrBit());
        req.carryIn = lfsrBit();
        return req;
    endfunction

    // Effective operand signs agree and both magnitudes are at least 2^30.
    function automatic arithReq_t overflowRequest();
        arithReq_t req;
        req.operandA.fields.sign = lfsrBit();
        req.op = arithOp_t'(lfsrBit());
        req.operandB.fields.sign = (req.op == opAdd) ? req.operandA.fields.sign
                                                     : !req.operandA.fields.sign;
        req.operandA.fields.magnitude = {1'b1, 30'(randomBits(30))};
        req.operandB.fields.magnitude = {1'b1, 30'(randomBits(30))};
        req.carryIn = lfsrBit();
        return req;
    endfunction

    initial begin
        int startCredits;
        int startResults;
        clk = 1'b0;
        arstN = 1'b0;
        reqValid = 1'b0;
        reqData = '0;
        rspCredit = 1'b0;
        grantNext = 1'b0;
        applyReset();

        checkTrue(rspValid == 1'b0, "rspValid was high after reset");
        checkTrue(reqCredit == 1'b0, "reqCredit was high after reset");
        sendRequest(randomRequest(12));
        repeat (6) @(posedge clk);
        #1;
        checkTrue(resultCount == 0, "a result left without downstream credits");
        finishTest("reset");

        grantAlways = 1'b1;
        repeat (60) sendRequest(randomRequest(12));
        waitForDrain();
        finishTest("random small add/sub");

        sendRequest(makeRequest(1'b1, 31'd0, opAdd, 1'b0, 31'd0, 1'b0));
        sendRequest(makeRequest(1'b1, 31'd0, opSub, 1'b1, 31'd0, 1'b0));
        sendRequest(makeRequest(1'b0, 31'd9, opSub, 1'b0, 31'd9, 1'b1));
        sendRequest(makeRequest(1'b1, 31'd9, opSub, 1'b1, 31'd9, 1'b0));
        sendRequest(makeRequest(1'b0, 31'd5, opAdd, 1'b1, 31'd5, 1'b0));
        sendRequest(makeRequest(1'b1, 31'd0, opAdd, 1'b1, 31'd0, 1'b1));
        sendRequest(makeRequest(1'b1, 31'd1, opAdd, 1'b0, 31'd0, 1'b1));
        sendRequest(makeRequest(1'b1, 31'd0, opSub, 1'b0, 31'd0, 1'b1));
        sendRequest(makeRequest(1'b0, 31'h7FFF_FFFF, opSub, 1'b0, 31'h7FFF_FFFF, 1'b0));
        sendRequest(makeRequest(1'b1, 31'h7FFF_FFFF, opAdd, 1'b0, 31'h7FFF_FFFF, 1'b1));
        waitForDrain();
        finishTest("signed zeros and carry edges");

        repeat (40) sendRequest(overflowRequest());
        sendRequest(makeRequest(1'b0, 31'h7FFF_FFFF, opAdd, 1'b0, 31'd0, 1'b1));
        sendRequest(makeRequest(1'b1, 31'h7FFF_FFFF, opSub, 1'b0, 31'd0, 1'b1));
        sendRequest(makeRequest(1'b1, 31'h7FFF_FFFF, opAdd, 1'b1, 31'd1, 1'b0));
        waitForDrain();
        finishTest("overflow");

        applyReset();
        startCredits = reqCreditCount;
        startResults = resultCount;
        repeat (queueDepth) sendRequest(randomRequest(20));
        repeat (8) @(posedge clk);
        #1;
        checkTrue(reqCreditCount == startCredits, "reqCredit pulsed with no result leaving");
        checkTrue(resultCount == startResults, "a result left without downstream credits");
        for (int i = 1; i <= queueDepth; i++) begin
            pendingGrants = 1;
            waitForResults(startResults + i);
            // Give a second result time to show up if one credit were spent twice.
            repeat (3) @(posedge clk);
            #1;
            checkTrue(resultCount == startResults + i, "more results left than credits granted");
            checkTrue(reqCreditCount - startCredits == i, "reqCredit count differs from results");
        end
        finishTest("back-pressure");

        grantAlways = 1'b1;
        startCredits = reqCreditCount;
        repeat (200) sendRequest(randomRequest(30));
        waitForDrain();
        checkTrue(reqCreditCount - startCredits == 200, "reqCredit pulses differ from requests");
        finishTest("streaming");

        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog/arithUnitTop.sv ====
// Top of the arithmetic unit; the upstream starts with queueDepth credits, the downstream with none.
`timescale 1ns/1ps

module arithUnitTop (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      reqValid,
    input  arithStreamPkg::arithReq_t reqData,
    output logic                      reqCredit,
    input  logic                      rspCredit,
    output logic                      rspValid,
    output arithStreamPkg::arithRsp_t rspData
);
    import arithStreamPkg::*;

    logic      stageValid;
    arithRsp_t stageRsp;

    trueFormArithStage stage (
        .clk        (clk),
        .arstN      (arstN),
        .reqValid   (reqValid),
        .reqData    (reqData),
        .stageValid (stageValid),
        .stageRsp   (stageRsp)
    );

    // Results wait here until the downstream grants credits.
    resultChannel channel (
        .clk        (clk),
        .arstN      (arstN),
        .stageValid (stageValid),
        .stageRsp   (stageRsp),
        .rspCredit  (rspCredit),
        .rspValid   (rspValid),
        .rspData    (rspData),
        .reqCredit  (reqCredit)
    );

endmodule

// ==== verilog/resultChannel.sv ====
// Result queue; the writer must respect upstream credits, since a write is never refused.
`timescale 1ns/1ps

module resultChannel (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      stageValid,
    input  arithStreamPkg::arithRsp_t stageRsp,
    input  logic                      rspCredit,
    output logic                      rspValid,
    output arithStreamPkg::arithRsp_t rspData,
    output logic                      reqCredit
);
    import arithStreamPkg::*;

    arithRsp_t                   entries [queueDepth];
    logic [queuePtrWidth-1:0]    writePtr;
    logic [queuePtrWidth-1:0]    readPtr;
    logic [queueCountWidth-1:0]  fillCount;
    logic [creditCountWidth-1:0] downCredits;
    logic                        sendNow;

    // A result leaves when one is waiting and the downstream has granted room.
    assign sendNow = (fillCount != '0) && (downCredits != '0);

    assign rspValid = sendNow;
    assign rspData = entries[readPtr];

    // Every departure frees a slot, so one credit goes back upstream.
    assign reqCredit = sendNow;

    always_ff @(posedge clk) begin
        if (stageValid) begin
            entries[writePtr] <= stageRsp;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            writePtr <= '0;
            readPtr <= '0;
            fillCount <= '0;
        end else begin
            if (stageValid) begin
                writePtr <= writePtr + 1'b1;
            end
            if (sendNow) begin
                readPtr <= readPtr + 1'b1;
            end
            case ({stageValid, sendNow})
                2'b10:   fillCount <= fillCount + 1'b1;
                2'b01:   fillCount <= fillCount - 1'b1;
                default: fillCount <= fillCount;
            endcase
        end
    end

    // Grants and sends in the same cycle cancel out.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            downCredits <= '0;
        end else begin
            case ({rspCredit, sendNow})
                2'b10:   downCredits <= downCredits + 1'b1;
                2'b01:   downCredits <= downCredits - 1'b1;
                default: downCredits <= downCredits;
            endcase
        end
    end

    // A write into a full queue means the upstream sent without holding a credit.
    writeNotFull: assert property (
        @(posedge clk) disable iff (!arstN)
        stageValid |-> (fillCount != queueCountWidth'(queueDepth))
    ) else $error("result queue written while full");

    // The downstream must not grant more credits than the counter can hold.
    creditNoWrap: assert property (
        @(posedge clk) disable iff (!arstN)
        (rspCredit && !sendNow) |-> (downCredits != '1)
    ) else $error("downstream credit counter wrapped");

endmodule

// ==== verilog/trueFormArithStage.sv ====
// One-cycle add/subtract stage; it accepts a request every cycle and cannot stall.
`timescale 1ns/1ps

module trueFormArithStage (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     reqValid,
    input  arithStreamPkg::arithReq_t reqData,
    output logic                     stageValid,
    output arithStreamPkg::arithRsp_t stageRsp
);
    import numFormatPkg::*;
    import arithStreamPkg::*;

    complementWord_t compA;
    complementWord_t compB;
    complementWord_t addendB;
    complementWord_t sumWord;
    logic            addCarry;
    logic            sumCarryOut;
    logic            signOverflow;
    signMagWord_t    resultWord;
    arithRsp_t       nextRsp;

    trueToComplement convA (
        .trueWord       (reqData.operandA),
        .complementWord (compA)
    );

    trueToComplement convB (
        .trueWord       (reqData.operandB),
        .complementWord (compB)
    );

    // Subtract adds ~B and ~borrow, which gives A - B - borrow.
    assign addendB = (reqData.op == opSub) ? ~compB : compB;
    assign addCarry = (reqData.op == opSub) ? ~reqData.carryIn : reqData.carryIn;

    carryLookaheadAdder mainAdder (
        .operandX (compA),
        .operandY (addendB),
        .carryIn  (addCarry),
        .sum      (sumWord),
        .carryOut (sumCarryOut)
    );

    complementToTrue convBack (
        .complementWord (sumWord),
        .trueWord       (resultWord)
    );

    // The carry into the sign bit differs from the carry out of it exactly when both
    // addends share a sign that the sum does not have.
    assign signOverflow = sumCarryOut ^ sumWord[wordWidth-1]
                        ^ compA[wordWidth-1] ^ addendB[wordWidth-1];

    always_comb begin
        nextRsp.result = resultWord;
        nextRsp.negative = sumWord[wordWidth-1];
        // -2^31 fits the adder but not the true form.
        nextRsp.overflow = signOverflow || (sumWord == {1'b1, {magWidth{1'b0}}});
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stageValid <= 1'b0;
        end else begin
            stageValid <= reqValid;
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid) begin
            stageRsp <= nextRsp;
        end
    end

endmodule

// ==== verilog/formatConverters.sv ====
// Format converters; 0x80000000 has no true form and maps to +0, so callers must flag it.
`timescale 1ns/1ps

module trueToComplement (
    input  numFormatPkg::signMagWord_t    trueWord,
    output numFormatPkg::complementWord_t complementWord
);
    import numFormatPkg::*;

    complementWord_t negSum;
    logic            negCarry;

    // With the top bit set, {1, ~mag} + 1 equals 2^32 - mag, which is -mag.
    carryLookaheadAdder negAdder (
        .operandX ({1'b1, ~trueWord.fields.magnitude}),
        .operandY ('0),
        .carryIn  (1'b1),
        .sum      (negSum),
        .carryOut (negCarry)
    );

    // The carry only comes out when the magnitude is zero, so -0 falls through to 0.
    assign complementWord = (trueWord.fields.sign && !negCarry) ?
                            negSum : {1'b0, trueWord.fields.magnitude};

endmodule

module complementToTrue (
    input  numFormatPkg::complementWord_t complementWord,
    output numFormatPkg::signMagWord_t    trueWord
);
    import numFormatPkg::*;

    complementWord_t lowMinusOne;
    logic            noBorrow;
    logic            hasMagnitude;

    // Adding all ones subtracts one from the lower 31 bits.
    carryLookaheadAdder decAdder (
        .operandX ({1'b0, complementWord[magWidth-1:0]}),
        .operandY ('1),
        .carryIn  (1'b0),
        .sum      (lowMinusOne),
        .carryOut (noBorrow)
    );

    // Both a carry out and a clear top bit say the lower part was not zero.
    assign hasMagnitude = noBorrow & ~lowMinusOne[wordWidth-1];

    always_comb begin
        if (complementWord[wordWidth-1]) begin
            trueWord.fields.sign = hasMagnitude;
            trueWord.fields.magnitude = hasMagnitude ? ~lowMinusOne[magWidth-1:0] : '0;
        end else begin
            trueWord.fields.sign = 1'b0;
            trueWord.fields.magnitude = complementWord[magWidth-1:0];
        end
    end

    // A negative result must carry a magnitude, whatever word comes in.
    always_comb begin
        assert final (trueWord.raw != {1'b1, {magWidth{1'b0}}})
            else $error("complementToTrue produced negative zero");
    end

endmodule

// ==== verilog/carryLookaheadAdder.sv ====
// Purely combinational; carryOut is the unsigned carry from bit 31, not a signed overflow.
`timescale 1ns/1ps

module carryLookaheadAdder (
    input  numFormatPkg::complementWord_t operandX,
    input  numFormatPkg::complementWord_t operandY,
    input  logic                          carryIn,
    output numFormatPkg::complementWord_t sum,
    output logic                          carryOut
);
    import numFormatPkg::*;

    complementWord_t          bitProp;
    complementWord_t          bitGen;
    complementWord_t          bitCarry;
    logic [claGroupCount-1:0] groupProp;
    logic [claGroupCount-1:0] groupGen;
    logic [claGroupCount:0]   groupCarry;

    assign bitProp = operandX ^ operandY;
    assign bitGen = operandX & operandY;

    // Each group propagates when all its bits do, and generates from its top bit down.
    always_comb begin : groupTerms
        logic gen;
        for (int g = 0; g < claGroupCount; g++) begin
            groupProp[g] = &bitProp[g*claGroupWidth +: claGroupWidth];
            gen = 1'b0;
            for (int b = 0; b < claGroupWidth; b++) begin
                gen = bitGen[g*claGroupWidth + b] | (bitProp[g*claGroupWidth + b] & gen);
            end
            groupGen[g] = gen;
        end
    end

    // Second level. Every group carry is a flat sum of products over the lower groups.
    always_comb begin : groupLookahead
        logic carry;
        logic chainProp;
        groupCarry[0] = carryIn;
        for (int g = 1; g <= claGroupCount; g++) begin
            carry = 1'b0;
            chainProp = 1'b1;
            for (int k = g - 1; k >= 0; k--) begin
                carry = carry | (chainProp & groupGen[k]);
                chainProp = chainProp & groupProp[k];
            end
            groupCarry[g] = carry | (chainProp & carryIn);
        end
    end

    // Inside a group the carries start from the group carry.
    always_comb begin : bitCarries
        logic ripple;
        for (int g = 0; g < claGroupCount; g++) begin
            ripple = groupCarry[g];
            for (int b = 0; b < claGroupWidth; b++) begin
                bitCarry[g*claGroupWidth + b] = ripple;
                ripple = bitGen[g*claGroupWidth + b] | (bitProp[g*claGroupWidth + b] & ripple);
            end
        end
    end

    assign sum = bitProp ^ bitCarry;
    assign carryOut = groupCarry[claGroupCount];

endmodule

// ==== verilog/arithStreamPkg.sv ====
// Stream types for the arithmetic unit; queueDepth must stay a power of two for pointer wrap.
package arithStreamPkg;

    // Number of result slots, and the credits the upstream holds after reset.
    localparam int queueDepth = 4;
    localparam int queuePtrWidth = $clog2(queueDepth);
    localparam int queueCountWidth = $clog2(queueDepth + 1);

    // Width of the downstream credit counter.
    localparam int creditCountWidth = 8;

    typedef enum logic {
        opAdd = 1'b0,
        opSub = 1'b1
    } arithOp_t;

    // One request. carryIn is a carry for add and a borrow for subtract.
    typedef struct packed {
        numFormatPkg::signMagWord_t operandA;
        numFormatPkg::signMagWord_t operandB;
        arithOp_t                   op;
        logic                       carryIn;
    } arithReq_t;

    // One result. negative is the sign of the two's-complement sum.
    typedef struct packed {
        numFormatPkg::signMagWord_t result;
        logic                       negative;
        logic                       overflow;
    } arithRsp_t;

endpackage

// ==== verilog/numFormatPkg.sv ====
// Word formats only; the magnitude view assumes the sign sits in the top bit of the word.
package numFormatPkg;

    // Width of every data word handled by the unit.
    localparam int wordWidth = 32;

    // The magnitude takes all bits below the sign.
    localparam int magWidth = wordWidth - 1;

    // The adder is split into groups of this many bits for carry lookahead.
    localparam int claGroupWidth = 4;
    localparam int claGroupCount = wordWidth / claGroupWidth;

    // Two's-complement word as it travels through the adders.
    typedef logic [wordWidth-1:0] complementWord_t;

    // Sign-magnitude fields, sign first.
    typedef struct packed {
        logic                sign;
        logic [magWidth-1:0] magnitude;
    } signMagFields_t;

    // One true-form word, seen either by field or as a plain word.
    typedef union packed {
        signMagFields_t       fields;
        logic [wordWidth-1:0] raw;
    } signMagWord_t;

endpackage
